// ==== hw/step_calc_pkg.sv ====
`default_nettype none

package step_calc_pkg;

  localparam int NUM_CH = 249;
  localparam int CH_W = 8;
  localparam int PHASE_W = 8;
  localparam int STEPS_W = 16;

  // latency of each pipeline block, from phase input to rate output
  localparam int FOLD_LAT = 2;
  localparam int DIV_LAT = STEPS_W;
  localparam int DIST_LAT = 2;
  localparam int PIPE_LAT = FOLD_LAT + DIV_LAT + DIST_LAT;

  // width of the drain timer that covers the whole pipeline
  localparam int DRAIN_W = $clog2(PIPE_LAT);

  typedef logic [PHASE_W-1:0] phase_t;
  typedef logic [STEPS_W-1:0] steps_t;
  typedef logic [CH_W-1:0] ch_t;

  typedef enum logic [1:0] {
    CLEAR,
    IDLE,
    RUN,
    DRAIN
  } seq_state_t;

endpackage

`default_nettype wire

// ==== hw/step_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface step_bus_if;

  logic valid;
  step_calc_pkg::ch_t ch;
  logic changed;
  // dividend on the fold side, quotient and remainder on the divider side
  step_calc_pkg::steps_t dividend;
  step_calc_pkg::steps_t quotient;
  step_calc_pkg::steps_t remainder;

  modport src (
    output valid,
    output ch,
    output changed,
    output dividend,
    output quotient,
    output remainder
  );

  modport dst (
    input valid,
    input ch,
    input changed,
    input dividend,
    input quotient,
    input remainder
  );

endinterface

`default_nettype wire

// ==== hw/phase_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module phase_mem #(
  parameter int WIDTH = 8
) (
  input var CLK,
  input var step_calc_pkg::ch_t rd_addr,
  output logic [WIDTH-1:0] rd_data,
  input var wr_en,
  input var step_calc_pkg::ch_t wr_addr,
  input var [WIDTH-1:0] wr_data
);

  logic [WIDTH-1:0] mem [step_calc_pkg::NUM_CH];

  // a read and a write to the same address return the old word
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== hw/channel_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module channel_counter (
  input var CLK,
  input var reset_out,
  input var ch_clear,
  input var ch_step,
  output step_calc_pkg::ch_t ch_idx,
  output logic ch_last,
  input var drain_start,
  output logic drain_done
);

  logic [step_calc_pkg::DRAIN_W-1:0] drain_cnt;
  logic drain_act;

  assign ch_last = (ch_idx == step_calc_pkg::ch_t'(step_calc_pkg::NUM_CH - 1));

  // wraps to zero after the last channel so the next pass starts clean
  always_ff @(posedge CLK) begin
    if (reset_out) begin
      ch_idx <= '0;
    end else if (ch_clear) begin
      ch_idx <= '0;
    end else if (ch_step) begin
      if (ch_last) begin
        ch_idx <= '0;
      end else begin
        ch_idx <= ch_idx + 1'b1;
      end
    end
  end

  assign drain_done = drain_act && (drain_cnt == '0);

  // done is raised on the last of PIPE_LAT drain cycles
  always_ff @(posedge CLK) begin
    if (reset_out) begin
      drain_act <= 1'b0;
      drain_cnt <= '0;
    end else if (drain_start) begin
      drain_act <= 1'b1;
      drain_cnt <= step_calc_pkg::DRAIN_W'(step_calc_pkg::PIPE_LAT - 1);
    end else if (drain_done) begin
      drain_act <= 1'b0;
    end else if (drain_act) begin
      drain_cnt <= drain_cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/channel_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module channel_sequencer (
  input var CLK,
  input var reset_out,
  input var frame_start,
  output logic busy,
  output logic ch_clear,
  output logic ch_step,
  input var step_calc_pkg::ch_t ch_idx,
  input var ch_last,
  output logic drain_start,
  input var drain_done,
  output logic ch_valid,
  output logic clr_en,
  output step_calc_pkg::ch_t clr_addr,
  output step_calc_pkg::steps_t steps_hold,
  input var step_calc_pkg::steps_t completion_steps
);

  step_calc_pkg::seq_state_t state;
  step_calc_pkg::seq_state_t state_nxt;
  logic start_ok;

  // a start outside IDLE is dropped
  assign start_ok = (state == step_calc_pkg::IDLE) && frame_start;

  always_comb begin
    state_nxt = state;
    case (state)
      step_calc_pkg::CLEAR: if (ch_last) state_nxt = step_calc_pkg::IDLE;
      step_calc_pkg::IDLE:  if (frame_start) state_nxt = step_calc_pkg::RUN;
      step_calc_pkg::RUN:   if (ch_last) state_nxt = step_calc_pkg::DRAIN;
      step_calc_pkg::DRAIN: if (drain_done) state_nxt = step_calc_pkg::IDLE;
      default:              state_nxt = step_calc_pkg::IDLE;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset_out) begin
      state <= step_calc_pkg::CLEAR;
    end else begin
      state <= state_nxt;
    end
  end

  // the step count is the divisor for every channel of the frame
  always_ff @(posedge CLK) begin
    if (reset_out) begin
      steps_hold <= '0;
    end else if (start_ok) begin
      steps_hold <= completion_steps;
    end
  end

  assign busy = (state != step_calc_pkg::IDLE);
  assign ch_clear = (state == step_calc_pkg::IDLE);
  assign ch_step = (state == step_calc_pkg::CLEAR) || (state == step_calc_pkg::RUN);
  assign ch_valid = (state == step_calc_pkg::RUN);
  assign drain_start = (state == step_calc_pkg::RUN) && ch_last;
  assign clr_en = (state == step_calc_pkg::CLEAR);
  assign clr_addr = ch_idx;

endmodule

`default_nettype wire

// ==== hw/phase_fold.sv ====
`timescale 1ns/1ps
`default_nettype none

module phase_fold (
  input var CLK,
  input var reset_out,
  input var ch_valid,
  input var step_calc_pkg::ch_t ch_idx,
  input var step_calc_pkg::phase_t phase,
  input var clr_en,
  input var step_calc_pkg::ch_t clr_addr,
  step_bus_if.src out
);

  logic s1_valid;
  step_calc_pkg::ch_t s1_ch;
  step_calc_pkg::phase_t s1_phase;
  step_calc_pkg::phase_t tgt_rd;
  step_calc_pkg::phase_t dist_rd;

  step_calc_pkg::phase_t diff;
  step_calc_pkg::phase_t dist_new;
  step_calc_pkg::phase_t dist_sel;
  logic changed;

  logic wr_en;
  step_calc_pkg::ch_t wr_addr;
  step_calc_pkg::phase_t tgt_wr;
  step_calc_pkg::phase_t dist_wr;

  phase_mem #(
    .WIDTH(step_calc_pkg::PHASE_W)
  ) u_tgt_mem (
    .CLK    (CLK),
    .rd_addr(ch_idx),
    .rd_data(tgt_rd),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(tgt_wr)
  );

  phase_mem #(
    .WIDTH(step_calc_pkg::PHASE_W)
  ) u_dist_mem (
    .CLK    (CLK),
    .rd_addr(ch_idx),
    .rd_data(dist_rd),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(dist_wr)
  );

  always_ff @(posedge CLK) begin
    s1_ch <= ch_idx;
    s1_phase <= phase;
    if (reset_out) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= ch_valid;
    end
  end

  // the shorter way around the circle, so 128 stays 128
  assign diff = s1_phase - tgt_rd;
  assign changed = (diff != '0);
  assign dist_new = diff[step_calc_pkg::PHASE_W-1] ? (8'd0 - diff) : diff;
  assign dist_sel = changed ? dist_new : dist_rd;

  assign wr_en = clr_en || (s1_valid && changed);
  assign wr_addr = clr_en ? clr_addr : s1_ch;
  assign tgt_wr = clr_en ? '0 : s1_phase;
  assign dist_wr = clr_en ? '0 : dist_new;

  always_ff @(posedge CLK) begin
    out.ch <= s1_ch;
    out.changed <= changed;
    out.dividend <= {dist_sel, 8'h00};
    if (reset_out) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= s1_valid;
    end
  end

  // result lanes are filled in by the divider
  assign out.quotient = '0;
  assign out.remainder = '0;

endmodule

`default_nettype wire

// ==== hw/step_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_divider (
  input var CLK,
  input var reset_out,
  input var step_calc_pkg::steps_t steps_hold,
  step_bus_if.dst in,
  step_bus_if.src out
);

  step_calc_pkg::steps_t rem_q [step_calc_pkg::DIV_LAT];
  step_calc_pkg::steps_t num_q [step_calc_pkg::DIV_LAT];
  step_calc_pkg::ch_t ch_q [step_calc_pkg::DIV_LAT];
  logic chg_q [step_calc_pkg::DIV_LAT];
  logic [step_calc_pkg::DIV_LAT-1:0] vld_q;

  // one restoring step, num shifts dividend bits out at the top and quotient bits in below
  function automatic logic [2*step_calc_pkg::STEPS_W-1:0] div_step(
    input step_calc_pkg::steps_t rem_in,
    input step_calc_pkg::steps_t num_in,
    input step_calc_pkg::steps_t divisor
  );
    logic [step_calc_pkg::STEPS_W:0] trial;
    step_calc_pkg::steps_t rem_out;
    step_calc_pkg::steps_t num_out;
    trial = {rem_in, num_in[step_calc_pkg::STEPS_W-1]};
    if (trial >= {1'b0, divisor}) begin
      rem_out = step_calc_pkg::steps_t'(trial - {1'b0, divisor});
      num_out = {num_in[step_calc_pkg::STEPS_W-2:0], 1'b1};
    end else begin
      rem_out = trial[step_calc_pkg::STEPS_W-1:0];
      num_out = {num_in[step_calc_pkg::STEPS_W-2:0], 1'b0};
    end
    return {rem_out, num_out};
  endfunction

  // a zero divisor passes every trial, so the quotient is all ones and the remainder the dividend
  always_ff @(posedge CLK) begin
    {rem_q[0], num_q[0]} <= div_step('0, in.dividend, steps_hold);
    ch_q[0] <= in.ch;
    chg_q[0] <= in.changed;
    for (int s = 1; s < step_calc_pkg::DIV_LAT; s++) begin
      {rem_q[s], num_q[s]} <= div_step(rem_q[s-1], num_q[s-1], steps_hold);
      ch_q[s] <= ch_q[s-1];
      chg_q[s] <= chg_q[s-1];
    end
  end

  always_ff @(posedge CLK) begin
    if (reset_out) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[step_calc_pkg::DIV_LAT-2:0], in.valid};
    end
  end

  assign out.valid = vld_q[step_calc_pkg::DIV_LAT-1];
  assign out.ch = ch_q[step_calc_pkg::DIV_LAT-1];
  assign out.changed = chg_q[step_calc_pkg::DIV_LAT-1];
  assign out.quotient = num_q[step_calc_pkg::DIV_LAT-1];
  assign out.remainder = rem_q[step_calc_pkg::DIV_LAT-1];
  // every dividend bit has been consumed by the last stage
  assign out.dividend = '0;

endmodule

`default_nettype wire

// ==== hw/remainder_dist.sv ====
`timescale 1ns/1ps
`default_nettype none

module remainder_dist (
  input var CLK,
  input var reset_out,
  step_bus_if.dst in,
  input var clr_en,
  input var step_calc_pkg::ch_t clr_addr,
  output logic rate_valid,
  output step_calc_pkg::ch_t rate_ch,
  output step_calc_pkg::steps_t update_rate
);

  logic s1_valid;
  step_calc_pkg::ch_t s1_ch;
  logic s1_changed;
  step_calc_pkg::steps_t s1_quo;
  step_calc_pkg::steps_t s1_rem;
  step_calc_pkg::steps_t rem_rd;

  step_calc_pkg::steps_t rate_nxt;
  step_calc_pkg::steps_t rem_nxt;

  logic wr_en;
  step_calc_pkg::ch_t wr_addr;
  step_calc_pkg::steps_t wr_data;

  phase_mem #(
    .WIDTH(step_calc_pkg::STEPS_W)
  ) u_rem_mem (
    .CLK    (CLK),
    .rd_addr(in.ch),
    .rd_data(rem_rd),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data)
  );

  always_ff @(posedge CLK) begin
    s1_ch <= in.ch;
    s1_changed <= in.changed;
    s1_quo <= in.quotient;
    s1_rem <= in.remainder;
    if (reset_out) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in.valid;
    end
  end

  // a new target restarts the spread with the fresh remainder
  always_comb begin
    if (s1_changed) begin
      rate_nxt = s1_quo;
      rem_nxt = s1_rem;
    end else if (rem_rd != '0) begin
      rate_nxt = s1_quo + 1'b1;
      rem_nxt = rem_rd - 1'b1;
    end else begin
      rate_nxt = s1_quo;
      rem_nxt = '0;
    end
  end

  assign wr_en = clr_en || s1_valid;
  assign wr_addr = clr_en ? clr_addr : s1_ch;
  assign wr_data = clr_en ? '0 : rem_nxt;

  always_ff @(posedge CLK) begin
    rate_ch <= s1_ch;
    update_rate <= rate_nxt;
    if (reset_out) begin
      rate_valid <= 1'b0;
    end else begin
      rate_valid <= s1_valid;
    end
  end

endmodule

`default_nettype wire

// ==== hw/step_calculator.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_calculator (
  input var CLK,
  input var reset_out,
  input var frame_start,
  input var step_calc_pkg::steps_t completion_steps,
  input var step_calc_pkg::phase_t phase,
  output logic busy,
  output logic rate_valid,
  output step_calc_pkg::ch_t rate_ch,
  output step_calc_pkg::steps_t update_rate
);

  logic ch_clear;
  logic ch_step;
  step_calc_pkg::ch_t ch_idx;
  logic ch_last;
  logic drain_start;
  logic drain_done;
  logic ch_valid;
  logic clr_en;
  step_calc_pkg::ch_t clr_addr;
  step_calc_pkg::steps_t steps_hold;

  step_bus_if fold_bus ();
  step_bus_if div_bus ();

  channel_counter u_counter (
    .CLK        (CLK),
    .reset_out  (reset_out),
    .ch_clear   (ch_clear),
    .ch_step    (ch_step),
    .ch_idx     (ch_idx),
    .ch_last    (ch_last),
    .drain_start(drain_start),
    .drain_done (drain_done)
  );

  channel_sequencer u_seq (
    .CLK             (CLK),
    .reset_out       (reset_out),
    .frame_start     (frame_start),
    .busy            (busy),
    .ch_clear        (ch_clear),
    .ch_step         (ch_step),
    .ch_idx          (ch_idx),
    .ch_last         (ch_last),
    .drain_start     (drain_start),
    .drain_done      (drain_done),
    .ch_valid        (ch_valid),
    .clr_en          (clr_en),
    .clr_addr        (clr_addr),
    .steps_hold      (steps_hold),
    .completion_steps(completion_steps)
  );

  phase_fold u_fold (
    .CLK      (CLK),
    .reset_out(reset_out),
    .ch_valid (ch_valid),
    .ch_idx   (ch_idx),
    .phase    (phase),
    .clr_en   (clr_en),
    .clr_addr (clr_addr),
    .out      (fold_bus.src)
  );

  step_divider u_div (
    .CLK       (CLK),
    .reset_out (reset_out),
    .steps_hold(steps_hold),
    .in        (fold_bus.dst),
    .out       (div_bus.src)
  );

  remainder_dist u_dist (
    .CLK        (CLK),
    .reset_out  (reset_out),
    .in         (div_bus.dst),
    .clr_en     (clr_en),
    .clr_addr   (clr_addr),
    .rate_valid (rate_valid),
    .rate_ch    (rate_ch),
    .update_rate(update_rate)
  );

endmodule

`default_nettype wire

// ==== dv/step_calculator_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_calculator_chk (
  input var CLK,
  input var reset_out,
  input var busy,
  input var ch_valid,
  input var ch_last,
  input var rate_valid,
  input var step_calc_pkg::ch_t rate_ch
);

  int frame_fails = 0;
  int order_fails = 0;
  int drain_fails = 0;
  int last_fails = 0;
  int fail_cnt;

  assign fail_cnt = frame_fails + order_fails + drain_fails + last_fails;

  // rates only leave while the frame or its drain is running
  property p_valid_in_frame;
    @(posedge CLK) disable iff (reset_out)
      rate_valid |-> busy;
  endproperty

  property p_ch_order;
    @(posedge CLK) disable iff (reset_out)
      rate_valid && (rate_ch != step_calc_pkg::ch_t'(step_calc_pkg::NUM_CH - 1))
      |=> rate_valid && (rate_ch == step_calc_pkg::ch_t'($past(rate_ch) + 1'b1));
  endproperty

  // busy holds through the whole drain after the last channel enters
  property p_drain_len;
    @(posedge CLK) disable iff (reset_out)
      ch_valid && ch_last |=> busy [*step_calc_pkg::PIPE_LAT] ##1 !busy;
  endproperty

  property p_last_rate;
    @(posedge CLK) disable iff (reset_out)
      rate_valid && (rate_ch == step_calc_pkg::ch_t'(step_calc_pkg::NUM_CH - 1))
      |=> $fell(busy);
  endproperty

  a_valid_in_frame: assert property (p_valid_in_frame) else begin
    frame_fails++;
    $error("rate_valid seen while busy was low");
  end

  a_ch_order: assert property (p_ch_order) else begin
    order_fails++;
    $error("rate_ch did not advance by one on the next cycle");
  end

  a_drain_len: assert property (p_drain_len) else begin
    drain_fails++;
    $error("busy did not fall exactly PIPE_LAT cycles after the last channel");
  end

  a_last_rate: assert property (p_last_rate) else begin
    last_fails++;
    $error("busy did not fall on the cycle after the last rate of the frame");
  end

endmodule

bind step_calculator step_calculator_chk u_chk (
  .CLK       (CLK),
  .reset_out (reset_out),
  .busy      (busy),
  .ch_valid  (ch_valid),
  .ch_last   (ch_last),
  .rate_valid(rate_valid),
  .rate_ch   (rate_ch)
);

`default_nettype wire

// ==== dv/tb_step_calculator.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_step_calculator;

  localparam int NUM_FRAMES = 10;
  localparam int WATCHDOG_NS =
    NUM_FRAMES * (step_calc_pkg::NUM_CH + step_calc_pkg::PIPE_LAT + 10) * 4 * 2;
  localparam int MODE_RAND = 0;
  localparam int MODE_SAME = 1;
  localparam int MODE_WRAP = 2;
  localparam int MODE_MIX = 3;
  localparam int NO_POKE = -1;

  logic CLK;
  logic reset_out;
  logic frame_start;
  step_calc_pkg::steps_t completion_steps;
  step_calc_pkg::phase_t phase;
  logic busy;
  logic rate_valid;
  step_calc_pkg::ch_t rate_ch;
  step_calc_pkg::steps_t update_rate;

  // reference state per channel
  int tgt_m [step_calc_pkg::NUM_CH];
  int dist_m [step_calc_pkg::NUM_CH];
  int rem_m [step_calc_pkg::NUM_CH];
  int exp_ch [$];
  int exp_rate [$];
  int exp_stamp [$];

  logic [15:0] lfsr_state = 16'd53;
  int cyc = 0;
  int mismatch_cnt = 0;
  int protocol_cnt = 0;
  int checked_cnt = 0;
  int end_errs;
  int assert_fails;
  int e_ch;
  int e_rate;
  int e_stamp;

  step_calculator u_dut (
    .CLK             (CLK),
    .reset_out       (reset_out),
    .frame_start     (frame_start),
    .completion_steps(completion_steps),
    .phase           (phase),
    .busy            (busy),
    .rate_valid      (rate_valid),
    .rate_ch         (rate_ch),
    .update_rate     (update_rate)
  );

  always #2 CLK = ~CLK;

  always @(posedge CLK) begin
    cyc <= cyc + 1;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // the bit shifted out of the register is the random bit
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic int next_phase(input int mode, input int k);
    case (mode)
      MODE_SAME: return tgt_m[k];
      // offsets of 128 to 255 take the short way back across zero
      MODE_WRAP: return (tgt_m[k] + 128 + (k % 128)) % 256;
      MODE_MIX: begin
        if (rand_bits(1) == 1) begin
          return rand_bits(8);
        end
        return tgt_m[k];
      end
      default: return rand_bits(8);
    endcase
  endfunction

  task automatic predict(input int k, input int p, input int steps);
    int diff;
    int quo;
    diff = (p - tgt_m[k] + 256) % 256;
    if (diff != 0) begin
      dist_m[k] = (diff >= 128) ? 256 - diff : diff;
      tgt_m[k] = p;
      quo = dist_m[k] * 256 / steps;
      rem_m[k] = dist_m[k] * 256 % steps;
      exp_rate.push_back(quo);
    end else begin
      quo = dist_m[k] * 256 / steps;
      if (rem_m[k] != 0) begin
        exp_rate.push_back(quo + 1);
        rem_m[k] = rem_m[k] - 1;
      end else begin
        exp_rate.push_back(quo);
      end
    end
    exp_ch.push_back(k);
    exp_stamp.push_back(cyc);
  endtask

  task automatic wait_idle();
    @(negedge CLK);
    while (busy) begin
      @(negedge CLK);
    end
  endtask

  task automatic run_frame(input int steps, input int mode, input int poke_ch,
                           input bit poke_drain);
    int p;
    @(negedge CLK);
    frame_start = 1'b1;
    completion_steps = step_calc_pkg::steps_t'(steps);
    for (int k = 0; k < step_calc_pkg::NUM_CH; k++) begin
      @(negedge CLK);
      // zero on the port after the start shows that the held count is the divisor
      frame_start = (k == poke_ch);
      completion_steps = (k == poke_ch) ? 16'd1 : 16'd0;
      p = next_phase(mode, k);
      phase = step_calc_pkg::phase_t'(p);
      predict(k, p, steps);
    end
    @(negedge CLK);
    frame_start = 1'b0;
    completion_steps = '0;
    phase = '0;
    if (poke_drain) begin
      repeat (5) @(negedge CLK);
      frame_start = 1'b1;
      completion_steps = 16'd1;
      @(negedge CLK);
      frame_start = 1'b0;
      completion_steps = '0;
    end
    wait_idle();
  endtask

  always @(negedge CLK) begin
    if (!reset_out && rate_valid) begin
      if (exp_ch.size() == 0) begin
        $display("unexpected rate output at %0t for channel %0d", $time, rate_ch);
        protocol_cnt++;
      end else begin
        e_ch = exp_ch.pop_front();
        e_rate = exp_rate.pop_front();
        e_stamp = exp_stamp.pop_front();
        checked_cnt++;
        assert (int'(rate_ch) == e_ch) else begin
          $display("MISMATCH time=%0t signal=rate_ch expected=%0d actual=%0d",
                   $time, e_ch, rate_ch);
          mismatch_cnt++;
        end
        assert (int'(update_rate) == e_rate) else begin
          $display("MISMATCH time=%0t signal=update_rate expected=%0d actual=%0d",
                   $time, e_rate, update_rate);
          mismatch_cnt++;
        end
        assert (cyc - e_stamp == step_calc_pkg::PIPE_LAT) else begin
          $display("rate for channel %0d came %0d cycles after its phase instead of %0d",
                   e_ch, cyc - e_stamp, step_calc_pkg::PIPE_LAT);
          protocol_cnt++;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("checked %0d rates, %0d mismatches, %0d protocol errors",
             checked_cnt, mismatch_cnt, protocol_cnt);
    $display("Verification failed");
    $finish;
  end

  initial begin
    CLK = 1'b0;
    reset_out = 1'b1;
    frame_start = 1'b0;
    completion_steps = '0;
    phase = '0;
    end_errs = 0;
    for (int k = 0; k < step_calc_pkg::NUM_CH; k++) begin
      tgt_m[k] = 0;
      dist_m[k] = 0;
      rem_m[k] = 0;
    end
    repeat (5) @(negedge CLK);
    reset_out = 1'b0;
    // a start during the clear pass must be dropped
    @(negedge CLK);
    frame_start = 1'b1;
    completion_steps = 16'd9;
    @(negedge CLK);
    frame_start = 1'b0;
    completion_steps = '0;
    wait_idle();

    run_frame(3, MODE_RAND, NO_POKE, 1'b0);
    repeat (3) run_frame(3, MODE_SAME, NO_POKE, 1'b0);
    run_frame(rand_bits(12) + 1, MODE_WRAP, NO_POKE, 1'b0);
    run_frame(rand_bits(12) + 1, MODE_SAME, 120, 1'b1);
    repeat (4) run_frame(rand_bits(12) + 1, MODE_MIX, NO_POKE, 1'b0);

    repeat (3) @(negedge CLK);
    if (exp_ch.size() != 0) begin
      $display("%0d expected rates never appeared", exp_ch.size());
      end_errs++;
    end
    if (checked_cnt != NUM_FRAMES * step_calc_pkg::NUM_CH) begin
      $display("saw %0d rates where %0d were due", checked_cnt,
               NUM_FRAMES * step_calc_pkg::NUM_CH);
      end_errs++;
    end
    assert_fails = u_dut.u_chk.fail_cnt;
    $display("checked %0d rates, %0d mismatches, %0d protocol, %0d end, %0d assertion errors",
             checked_cnt, mismatch_cnt, protocol_cnt, end_errs, assert_fails);
    if (mismatch_cnt + protocol_cnt + end_errs + assert_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
hw/step_calc_pkg.sv
hw/step_bus_if.sv
hw/phase_mem.sv
hw/channel_counter.sv
hw/channel_sequencer.sv
hw/phase_fold.sv
hw/step_divider.sv
hw/remainder_dist.sv
hw/step_calculator.sv
dv/step_calculator_chk.sv
dv/tb_step_calculator.sv
